// ==== hw/rv_config.svh ====
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// datapath width, also used for the pc and the immediate
`define RV_XLEN 32

// register index width, sized for the rd/rs1/rs2 fields
`define RV_REG_ADDR_W 5

// number of architectural registers, x0 included
`define RV_NUM_REGS 32

`endif

// ==== hw/rv_pkg.sv ====
package rv_pkg;

    // major opcodes of the supported rv32i subset
    // all-zero word is used as the halt instruction
    typedef enum logic [6:0] {
        op_halt   = 7'b0000000,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    // write-back source for the result mux in wb
    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_pc4 = 2'd2
    } wb_sel_e;

    // instruction field positions, msb and lsb of each field
    localparam int opcode_msb = 6;
    localparam int opcode_lsb = 0;
    localparam int rd_msb     = 11;
    localparam int rd_lsb     = 7;
    localparam int funct3_msb = 14;
    localparam int funct3_lsb = 12;
    localparam int rs1_msb    = 19;
    localparam int rs1_lsb    = 15;
    localparam int rs2_msb    = 24;
    localparam int rs2_lsb    = 20;
    // S and B formats reuse this slot for upper immediate bits
    localparam int funct7_msb = 31;
    localparam int funct7_lsb = 25;

endpackage

// ==== hw/decode_ctrl_if.sv ====
`timescale 1ns/1ps

interface decode_ctrl_if;

    // alu operand selects
    logic            pc_rs1_sel;
    logic            imm_rs2_sel;
    // branch adder target select
    logic            jump_branch_sel;
    logic            mem_wr_en;
    logic            reg_wr_en;
    rv_pkg::wb_sel_e reg_wr_ctrl;
    // which source fields the instruction really reads
    logic            rs1_used;
    logic            rs2_used;

    // control unit drives the bundle
    modport ctrl (
        output pc_rs1_sel, imm_rs2_sel, jump_branch_sel, mem_wr_en,
        output reg_wr_en, reg_wr_ctrl, rs1_used, rs2_used
    );

    // hazard check only needs the source usage flags
    modport hazard (
        input rs1_used, rs2_used
    );

    // pipeline register reads everything
    modport stage (
        input pc_rs1_sel, imm_rs2_sel, jump_branch_sel, mem_wr_en,
        input reg_wr_en, reg_wr_ctrl, rs1_used, rs2_used
    );

endinterface

// ==== hw/imm_gen.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module imm_gen (
    input  logic [`RV_XLEN-1:0]        instruction,
    input  rv_pkg::opcode_e            opcode,
    output logic signed [`RV_XLEN-1:0] imm
);

    // sign bit sits at the top of every format
    logic sign;

    assign sign = instruction[`RV_XLEN-1];

    always_comb begin
        case (opcode)
            // I format, 12 bits from the top of the word
            rv_pkg::op_imm, rv_pkg::op_load, rv_pkg::op_jalr: begin
                imm = {{(`RV_XLEN-12){sign}}, instruction[31:20]};
            end
            // S format, upper part in the funct7 slot and lower part in the rd slot
            rv_pkg::op_store: begin
                imm = {{(`RV_XLEN-12){sign}},
                       instruction[rv_pkg::funct7_msb:rv_pkg::funct7_lsb],
                       instruction[rv_pkg::rd_msb:rv_pkg::rd_lsb]};
            end
            // B format, halfword offset so lsb is zero
            rv_pkg::op_branch: begin
                imm = {{(`RV_XLEN-13){sign}}, sign, instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            end
            // U format, upper 20 bits with the low 12 cleared
            rv_pkg::op_lui, rv_pkg::op_auipc: begin
                imm = {instruction[31:12], 12'b0};
            end
            // J format, also a halfword offset
            rv_pkg::op_jal: begin
                imm = {{(`RV_XLEN-21){sign}}, sign, instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
            end
            // reg-reg, halt and anything illegal carry no immediate
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== hw/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input rv_pkg::opcode_e opcode,
    decode_ctrl_if.ctrl    ctrl
);

    always_comb begin
        // everything off by default, halt and illegal opcodes stay here
        ctrl.pc_rs1_sel      = 1'b0;
        ctrl.imm_rs2_sel     = 1'b0;
        ctrl.jump_branch_sel = 1'b0;
        ctrl.mem_wr_en       = 1'b0;
        ctrl.reg_wr_en       = 1'b0;
        ctrl.reg_wr_ctrl     = rv_pkg::wb_alu;
        ctrl.rs1_used        = 1'b0;
        ctrl.rs2_used        = 1'b0;

        case (opcode)
            rv_pkg::op_lui: begin
                // rd = imm, rs1 field is part of the immediate
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.reg_wr_en   = 1'b1;
            end
            rv_pkg::op_auipc: begin
                ctrl.pc_rs1_sel  = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.reg_wr_en   = 1'b1;
            end
            rv_pkg::op_jal: begin
                // target from pc + imm, link value pc + 4
                ctrl.pc_rs1_sel      = 1'b1;
                ctrl.imm_rs2_sel     = 1'b1;
                ctrl.jump_branch_sel = 1'b1;
                ctrl.reg_wr_en       = 1'b1;
                ctrl.reg_wr_ctrl     = rv_pkg::wb_pc4;
            end
            rv_pkg::op_jalr: begin
                // target from rs1 + imm
                ctrl.imm_rs2_sel     = 1'b1;
                ctrl.jump_branch_sel = 1'b1;
                ctrl.reg_wr_en       = 1'b1;
                ctrl.reg_wr_ctrl     = rv_pkg::wb_pc4;
                ctrl.rs1_used        = 1'b1;
            end
            rv_pkg::op_branch: begin
                // alu compares rs1 with rs2, no write-back
                ctrl.rs1_used = 1'b1;
                ctrl.rs2_used = 1'b1;
            end
            rv_pkg::op_load: begin
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.reg_wr_en   = 1'b1;
                ctrl.reg_wr_ctrl = rv_pkg::wb_mem;
                ctrl.rs1_used    = 1'b1;
            end
            rv_pkg::op_store: begin
                // address from rs1 + imm, rs2 carries the store data
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.mem_wr_en   = 1'b1;
                ctrl.rs1_used    = 1'b1;
                ctrl.rs2_used    = 1'b1;
            end
            rv_pkg::op_imm: begin
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.reg_wr_en   = 1'b1;
                ctrl.rs1_used    = 1'b1;
            end
            rv_pkg::op_reg: begin
                ctrl.reg_wr_en = 1'b1;
                ctrl.rs1_used  = 1'b1;
                ctrl.rs2_used  = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module register_file (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [`RV_REG_ADDR_W-1:0] wr_addr,
    input  logic [`RV_XLEN-1:0]       wr_data,
    input  logic                      wr_en,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]       rs1_data,
    output logic [`RV_XLEN-1:0]       rs2_data
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

    // one read port: zero for x0, bypass a same-cycle write, else the array
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_ADDR_W-1:0] addr);
        logic [`RV_XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en && (wr_addr == addr)) begin
            data = wr_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            // writes to x0 are dropped
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module hazard_unit (
    input  rv_pkg::wb_sel_e             reg_wr_ctrl_idex,
    input  logic [`RV_REG_ADDR_W-1:0]   rd_idex,
    input  logic [`RV_REG_ADDR_W-1:0]   rs1,
    input  logic [`RV_REG_ADDR_W-1:0]   rs2,
    decode_ctrl_if.hazard               ctrl,
    output logic                        stall
);

    // load in ex whose data is not ready until mem
    logic load_in_ex;
    // match only counts when the field is a real source operand
    logic rs1_hit;
    logic rs2_hit;

    assign load_in_ex = (reg_wr_ctrl_idex == rv_pkg::wb_mem) && (rd_idex != '0);
    assign rs1_hit    = ctrl.rs1_used && (rs1 == rd_idex);
    assign rs2_hit    = ctrl.rs2_used && (rs2 == rd_idex);

    // one bubble is enough, the load has left ex on the next cycle
    assign stall = load_in_ex && (rs1_hit || rs2_hit);

endmodule

// ==== hw/instruction_decode.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module instruction_decode (
    input  logic                        clk,
    input  logic                        arst_n,
    // from fetch
    input  logic [`RV_XLEN-1:0]         instruction_ifid,
    input  logic [`RV_XLEN-1:0]         pc_ifid,
    input  logic [`RV_XLEN-1:0]         pc_4_ifid,
    // mul/div unit busy, freeze id/ex
    input  logic                        div_stall,
    // taken branch or jump in ex, kill the instruction in id
    input  logic                        pc_sel_exif,
    // from write-back
    input  logic [`RV_XLEN-1:0]         wb_data,
    input  logic [`RV_REG_ADDR_W-1:0]   wb_rd,
    input  logic                        wb_en,
    // to ex
    output rv_pkg::opcode_e             op_idex,
    output logic [6:0]                  funct7_idex,
    output logic [2:0]                  funct3_idex,
    output logic [`RV_XLEN-1:0]         rs1_data_idex,
    output logic [`RV_XLEN-1:0]         rs2_data_idex,
    output logic signed [`RV_XLEN-1:0]  immediate_idex,
    output logic [`RV_XLEN-1:0]         pc_idex,
    output logic [`RV_XLEN-1:0]         pc_4_idex,
    output logic                        jump_branch_sel_idex,
    output logic                        mem_wr_en_idex,
    output logic                        reg_wr_en_idex,
    output rv_pkg::wb_sel_e             reg_wr_ctrl_idex,
    output logic [`RV_REG_ADDR_W-1:0]   rd_idex,
    // source indices and operand selects for forwarding in ex
    output logic [`RV_REG_ADDR_W-1:0]   rs1_idex,
    output logic [`RV_REG_ADDR_W-1:0]   rs2_idex,
    output logic                        pc_rs1_sel_idex,
    output logic                        imm_rs2_sel_idex,
    output logic                        halt_ex,
    // load-use stall, fetch holds the instruction
    output logic                        stall
);

    rv_pkg::opcode_e             opcode;
    logic [6:0]                  funct7;
    logic [2:0]                  funct3;
    logic [`RV_REG_ADDR_W-1:0]   rd;
    logic [`RV_REG_ADDR_W-1:0]   rs1;
    logic [`RV_REG_ADDR_W-1:0]   rs2;
    logic signed [`RV_XLEN-1:0]  immediate;
    logic [`RV_XLEN-1:0]         rs1_data;
    logic [`RV_XLEN-1:0]         rs2_data;
    logic                        halt;
    logic                        load_bubble;

    // field extraction
    assign opcode = rv_pkg::opcode_e'(instruction_ifid[rv_pkg::opcode_msb:rv_pkg::opcode_lsb]);
    assign funct7 = instruction_ifid[rv_pkg::funct7_msb:rv_pkg::funct7_lsb];
    assign funct3 = instruction_ifid[rv_pkg::funct3_msb:rv_pkg::funct3_lsb];
    assign rd     = instruction_ifid[rv_pkg::rd_msb:rv_pkg::rd_lsb];
    assign rs1    = instruction_ifid[rv_pkg::rs1_msb:rv_pkg::rs1_lsb];
    assign rs2    = instruction_ifid[rv_pkg::rs2_msb:rv_pkg::rs2_lsb];

    // all-zero opcode stops the core once it reaches ex
    assign halt = (opcode == rv_pkg::op_halt);

    // flush and load-use both win over the div hold
    assign load_bubble = pc_sel_exif || stall;

    decode_ctrl_if u_ctrl_if ();

    imm_gen u_imm_gen (
        .instruction (instruction_ifid),
        .opcode      (opcode),
        .imm         (immediate)
    );

    control_unit u_control_unit (
        .opcode (opcode),
        .ctrl   (u_ctrl_if.ctrl)
    );

    register_file u_register_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data),
        .wr_en    (wb_en),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    hazard_unit u_hazard_unit (
        .reg_wr_ctrl_idex (reg_wr_ctrl_idex),
        .rd_idex          (rd_idex),
        .rs1              (rs1),
        .rs2              (rs2),
        .ctrl             (u_ctrl_if.hazard),
        .stall            (stall)
    );

    // id/ex register
    // bubble is an addi x0 style nop with no side effects
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_idex              <= rv_pkg::op_imm;
            funct7_idex          <= '0;
            funct3_idex          <= '0;
            rs1_data_idex        <= '0;
            rs2_data_idex        <= '0;
            immediate_idex       <= '0;
            pc_idex              <= '0;
            pc_4_idex            <= '0;
            jump_branch_sel_idex <= 1'b0;
            mem_wr_en_idex       <= 1'b0;
            reg_wr_en_idex       <= 1'b0;
            reg_wr_ctrl_idex     <= rv_pkg::wb_alu;
            rd_idex              <= '0;
            rs1_idex             <= '0;
            rs2_idex             <= '0;
            pc_rs1_sel_idex      <= 1'b0;
            imm_rs2_sel_idex     <= 1'b0;
            halt_ex              <= 1'b0;
        end else if (load_bubble || !div_stall) begin
            // hold case falls through and keeps the register as is
            op_idex              <= load_bubble ? rv_pkg::op_imm : opcode;
            funct7_idex          <= load_bubble ? '0 : funct7;
            funct3_idex          <= load_bubble ? '0 : funct3;
            rs1_data_idex        <= load_bubble ? '0 : rs1_data;
            rs2_data_idex        <= load_bubble ? '0 : rs2_data;
            immediate_idex       <= load_bubble ? '0 : immediate;
            pc_idex              <= load_bubble ? '0 : pc_ifid;
            pc_4_idex            <= load_bubble ? '0 : pc_4_ifid;
            jump_branch_sel_idex <= !load_bubble && u_ctrl_if.jump_branch_sel;
            mem_wr_en_idex       <= !load_bubble && u_ctrl_if.mem_wr_en;
            reg_wr_en_idex       <= !load_bubble && u_ctrl_if.reg_wr_en;
            reg_wr_ctrl_idex     <= load_bubble ? rv_pkg::wb_alu : u_ctrl_if.reg_wr_ctrl;
            rd_idex              <= load_bubble ? '0 : rd;
            rs1_idex             <= load_bubble ? '0 : rs1;
            rs2_idex             <= load_bubble ? '0 : rs2;
            pc_rs1_sel_idex      <= !load_bubble && u_ctrl_if.pc_rs1_sel;
            imm_rs2_sel_idex     <= !load_bubble && u_ctrl_if.imm_rs2_sel;
            halt_ex              <= !load_bubble && halt;
        end
    end

endmodule

// ==== test/tb_instruction_decode.sv ====
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_instruction_decode;

    localparam int reset_cycles    = 16;
    localparam int num_random      = 300;
    // upper bound for all directed sections together
    localparam int num_directed    = 150;
    // random instructions can take two cycles when they stall
    localparam int watchdog_cycles = 2 * (reset_cycles + 2 * num_random + num_directed);
    localparam logic [31:0] nop    = 32'h0000_0013;

    // expected id/ex contents, plus the source usage flags for the stall model
    typedef struct packed {
        logic [6:0]  op;
        logic [6:0]  funct7;
        logic [2:0]  funct3;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [31:0] pc_4;
        logic        jump_branch_sel;
        logic        mem_wr_en;
        logic        reg_wr_en;
        logic [1:0]  reg_wr_ctrl;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        pc_rs1_sel;
        logic        imm_rs2_sel;
        logic        halt;
        logic        rs1_used;
        logic        rs2_used;
    } idex_t;

    logic                              clk;
    logic                              arst_n;
    logic [`RV_XLEN-1:0]               instruction_ifid;
    logic [`RV_XLEN-1:0]               pc_ifid;
    logic [`RV_XLEN-1:0]               pc_4_ifid;
    logic                              div_stall;
    logic                              pc_sel_exif;
    logic [`RV_XLEN-1:0]               wb_data;
    logic [`RV_REG_ADDR_W-1:0]         wb_rd;
    logic                              wb_en;
    rv_pkg::opcode_e                   op_idex;
    logic [6:0]                        funct7_idex;
    logic [2:0]                        funct3_idex;
    logic [`RV_XLEN-1:0]               rs1_data_idex;
    logic [`RV_XLEN-1:0]               rs2_data_idex;
    logic signed [`RV_XLEN-1:0]        immediate_idex;
    logic [`RV_XLEN-1:0]               pc_idex;
    logic [`RV_XLEN-1:0]               pc_4_idex;
    logic                              jump_branch_sel_idex;
    logic                              mem_wr_en_idex;
    logic                              reg_wr_en_idex;
    rv_pkg::wb_sel_e                   reg_wr_ctrl_idex;
    logic [`RV_REG_ADDR_W-1:0]         rd_idex;
    logic [`RV_REG_ADDR_W-1:0]         rs1_idex;
    logic [`RV_REG_ADDR_W-1:0]         rs2_idex;
    logic                              pc_rs1_sel_idex;
    logic                              imm_rs2_sel_idex;
    logic                              halt_ex;
    logic                              stall;

    // model of the id/ex register and the queue of results still to compare
    idex_t       model;
    idex_t       bubble;
    idex_t       exp_q[$];
    string       name_q[$];
    // mirror of every write-back driven so far
    logic [31:0] shadow [0:`RV_NUM_REGS-1];
    logic [31:0] rng;
    logic [31:0] pc_ctr;
    int          n_checks;
    int          n_errors;

    instruction_decode u_instruction_decode (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // immediate bits packed at the top, arithmetic shift does the sign extension
    function automatic logic [31:0] sext_top(input logic [31:0] v, input int sh);
        return $signed(v) >>> sh;
    endfunction

    // x0 is zero, a write in the same cycle passes straight through
    function automatic logic [31:0] reg_value(input logic [4:0] idx, input logic wen,
                                              input logic [4:0] wrd, input logic [31:0] wdat);
        logic [31:0] v;
        if (idx == 5'd0) begin
            v = '0;
        end else if (wen && wrd == idx) begin
            v = wdat;
        end else begin
            v = shadow[idx];
        end
        return v;
    endfunction

    function automatic idex_t decode_ref(input logic [31:0] ins, input logic [31:0] pc,
                                         input logic wen, input logic [4:0] wrd,
                                         input logic [31:0] wdat);
        idex_t      r;
        logic [6:0] op;
        r  = '0;
        op = ins[rv_pkg::opcode_msb:rv_pkg::opcode_lsb];
        r.op     = op;
        r.funct7 = ins[rv_pkg::funct7_msb:rv_pkg::funct7_lsb];
        r.funct3 = ins[rv_pkg::funct3_msb:rv_pkg::funct3_lsb];
        r.rd     = ins[rv_pkg::rd_msb:rv_pkg::rd_lsb];
        r.rs1    = ins[rv_pkg::rs1_msb:rv_pkg::rs1_lsb];
        r.rs2    = ins[rv_pkg::rs2_msb:rv_pkg::rs2_lsb];
        r.pc     = pc;
        r.pc_4   = pc + 32'd4;
        r.rs1_data = reg_value(r.rs1, wen, wrd, wdat);
        r.rs2_data = reg_value(r.rs2, wen, wrd, wdat);
        // control table per opcode
        r.imm_rs2_sel = op inside {rv_pkg::op_imm, rv_pkg::op_load, rv_pkg::op_store,
                                   rv_pkg::op_lui, rv_pkg::op_auipc, rv_pkg::op_jal,
                                   rv_pkg::op_jalr};
        r.pc_rs1_sel      = op inside {rv_pkg::op_auipc, rv_pkg::op_jal};
        r.jump_branch_sel = op inside {rv_pkg::op_jal, rv_pkg::op_jalr};
        r.mem_wr_en       = (op == rv_pkg::op_store);
        r.reg_wr_en = op inside {rv_pkg::op_lui, rv_pkg::op_auipc, rv_pkg::op_jal,
                                 rv_pkg::op_jalr, rv_pkg::op_load, rv_pkg::op_imm,
                                 rv_pkg::op_reg};
        if (op == rv_pkg::op_load) begin
            r.reg_wr_ctrl = rv_pkg::wb_mem;
        end else if (r.jump_branch_sel) begin
            r.reg_wr_ctrl = rv_pkg::wb_pc4;
        end
        r.rs1_used = op inside {rv_pkg::op_jalr, rv_pkg::op_branch, rv_pkg::op_load,
                                rv_pkg::op_store, rv_pkg::op_imm, rv_pkg::op_reg};
        r.rs2_used = op inside {rv_pkg::op_branch, rv_pkg::op_store, rv_pkg::op_reg};
        r.halt     = (op == rv_pkg::op_halt);
        // immediate formats
        case (op)
            rv_pkg::op_imm, rv_pkg::op_load, rv_pkg::op_jalr: begin
                r.imm = sext_top(ins, 20);
            end
            rv_pkg::op_store: begin
                r.imm = sext_top({ins[31:25], ins[11:7], 20'h0}, 20);
            end
            rv_pkg::op_branch: begin
                r.imm = sext_top({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0, 19'h0}, 19);
            end
            rv_pkg::op_lui, rv_pkg::op_auipc: begin
                r.imm = {ins[31:12], 12'h0};
            end
            rv_pkg::op_jal: begin
                r.imm = sext_top({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0, 11'h0}, 11);
            end
            default: begin
                r.imm = '0;
            end
        endcase
        return r;
    endfunction

    // load in ex writing a register that the instruction in id really reads
    function automatic logic load_use(input idex_t ex, input idex_t id);
        return (ex.reg_wr_ctrl == rv_pkg::wb_mem) && (ex.rd != 5'd0) &&
               ((id.rs1_used && id.rs1 == ex.rd) || (id.rs2_used && id.rs2 == ex.rd));
    endfunction

    function automatic logic [31:0] make_instr(input logic [6:0] op, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'h00, rs2, rs1, 3'h0, rd, op};
    endfunction

    // random opcode, loads and reg-reg weighted up to provoke load-use cases
    function automatic logic [6:0] pick_opcode(input logic [3:0] sel);
        logic [6:0] op;
        case (sel)
            4'd0:         op = rv_pkg::op_lui;
            4'd1:         op = rv_pkg::op_auipc;
            4'd2:         op = rv_pkg::op_jal;
            4'd3:         op = rv_pkg::op_jalr;
            4'd4:         op = rv_pkg::op_branch;
            4'd5:         op = rv_pkg::op_store;
            4'd6:         op = rv_pkg::op_imm;
            4'd7:         op = rv_pkg::op_halt;
            4'd8, 4'd9:   op = rv_pkg::op_load;
            4'd10, 4'd11: op = rv_pkg::op_imm;
            default:      op = rv_pkg::op_reg;
        endcase
        return op;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_bundle(input string tn, input idex_t e);
        check_value({tn, ".op"}, 32'(e.op), 32'(op_idex));
        check_value({tn, ".funct7"}, 32'(e.funct7), 32'(funct7_idex));
        check_value({tn, ".funct3"}, 32'(e.funct3), 32'(funct3_idex));
        check_value({tn, ".rs1_data"}, e.rs1_data, rs1_data_idex);
        check_value({tn, ".rs2_data"}, e.rs2_data, rs2_data_idex);
        check_value({tn, ".imm"}, e.imm, immediate_idex);
        check_value({tn, ".pc"}, e.pc, pc_idex);
        check_value({tn, ".pc_4"}, e.pc_4, pc_4_idex);
        check_value({tn, ".jump_branch_sel"}, 32'(e.jump_branch_sel), 32'(jump_branch_sel_idex));
        check_value({tn, ".mem_wr_en"}, 32'(e.mem_wr_en), 32'(mem_wr_en_idex));
        check_value({tn, ".reg_wr_en"}, 32'(e.reg_wr_en), 32'(reg_wr_en_idex));
        check_value({tn, ".reg_wr_ctrl"}, 32'(e.reg_wr_ctrl), 32'(reg_wr_ctrl_idex));
        check_value({tn, ".rd"}, 32'(e.rd), 32'(rd_idex));
        check_value({tn, ".rs1"}, 32'(e.rs1), 32'(rs1_idex));
        check_value({tn, ".rs2"}, 32'(e.rs2), 32'(rs2_idex));
        check_value({tn, ".pc_rs1_sel"}, 32'(e.pc_rs1_sel), 32'(pc_rs1_sel_idex));
        check_value({tn, ".imm_rs2_sel"}, 32'(e.imm_rs2_sel), 32'(imm_rs2_sel_idex));
        check_value({tn, ".halt_ex"}, 32'(e.halt), 32'(halt_ex));
    endtask

    // one cycle of fetch, execute and write-back activity at the ports
    task automatic send(input string tn, input logic [31:0] ins, input logic flush,
                        input logic hold, input logic wen, input logic [4:0] wrd,
                        input logic [31:0] wdat, output bit stalled);
        idex_t dec;
        logic  exp_stall;
        @(negedge clk);
        instruction_ifid = ins;
        pc_ifid          = pc_ctr;
        pc_4_ifid        = pc_ctr + 32'd4;
        pc_sel_exif      = flush;
        div_stall        = hold;
        wb_en            = wen;
        wb_rd            = wrd;
        wb_data          = wdat;
        dec       = decode_ref(ins, pc_ctr, wen, wrd, wdat);
        exp_stall = load_use(model, dec);
        if (wen && wrd != 5'd0) begin
            shadow[wrd] = wdat;
        end
        // flush and stall load a bubble, hold keeps the register
        if (flush || exp_stall) begin
            model = bubble;
        end else if (!hold) begin
            model = dec;
        end
        exp_q.push_back(model);
        name_q.push_back(tn);
        // fetch keeps its pc while the stage does not accept
        if (!exp_stall && !hold) begin
            pc_ctr = pc_ctr + 32'd4;
        end
        #1;
        check_value({tn, ".stall"}, 32'(exp_stall), 32'(stall));
        stalled = exp_stall;
    endtask

    task automatic decode_one(input string tn, input logic [31:0] ins);
        bit st;
        send(tn, ins, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0, st);
    endtask

    // result of each accepted cycle is checked once the register has loaded
    always begin : compare_proc
        idex_t e;
        string tn;
        @(posedge clk);
        #1;
        if (exp_q.size() > 0) begin
            e  = exp_q.pop_front();
            tn = name_q.pop_front();
            compare_bundle(tn, e);
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the test sequence did not finish",
                 watchdog_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] ins;
        logic [31:0] wdat;
        logic [6:0]  op;
        logic [4:0]  wrd;
        logic        wen;
        logic        flush;
        logic        hold;
        bit          st;
        clk              = 1'b0;
        arst_n           = 1'b0;
        instruction_ifid = nop;
        pc_ifid          = '0;
        pc_4_ifid        = '0;
        div_stall        = 1'b0;
        // flush stays up until the first real instruction
        pc_sel_exif      = 1'b1;
        wb_data          = '0;
        wb_rd            = '0;
        wb_en            = 1'b0;
        rng              = 32'h5a75_7939;
        pc_ctr           = 32'h0000_1000;
        n_checks         = 0;
        n_errors         = 0;
        bubble           = '0;
        bubble.op        = rv_pkg::op_imm;
        model            = bubble;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            shadow[i] = '0;
        end

        // reset and halt
        repeat (reset_cycles / 2) @(posedge clk);
        @(negedge clk);
        compare_bundle("reset_active", bubble);
        repeat (reset_cycles / 2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        compare_bundle("reset_release", bubble);
        send("reset_flush", nop, 1'b1, 1'b0, 1'b0, 5'd0, 32'd0, st);
        decode_one("halt", 32'h0000_0000);
        decode_one("after_halt", nop);

        // fill the register file, x0 included
        for (int i = 1; i < `RV_NUM_REGS; i++) begin
            rng = xorshift(rng);
            send("rf_write", nop, 1'b0, 1'b0, 1'b1, 5'(i), rng, st);
        end
        send("rf_write_x0", nop, 1'b0, 1'b0, 1'b1, 5'd0, 32'hdead_beef, st);
        for (int i = 0; i < 16; i++) begin
            rng = xorshift(rng);
            decode_one("rf_read_reg", make_instr(rv_pkg::op_reg, rng[11:7], rng[19:15],
                                                 rng[24:20]));
            decode_one("rf_read_store", make_instr(rv_pkg::op_store, rng[4:0], rng[29:25],
                                                   rng[16:12]));
        end
        decode_one("rf_x0", make_instr(rv_pkg::op_reg, 5'd1, 5'd0, 5'd0));
        send("rf_write_through", make_instr(rv_pkg::op_reg, 5'd3, 5'd9, 5'd9),
             1'b0, 1'b0, 1'b1, 5'd9, 32'h1234_5678, st);
        send("rf_x0_through", make_instr(rv_pkg::op_store, 5'd0, 5'd0, 5'd0),
             1'b0, 1'b0, 1'b1, 5'd0, 32'hffff_ffff, st);

        // random decode with write-back traffic and occasional flush or hold
        for (int n = 0; n < num_random; n++) begin
            rng = xorshift(rng);
            op  = pick_opcode(rng[3:0]);
            ins = (op == rv_pkg::op_halt) ? 32'h0 : {rng[31:7], op};
            rng   = xorshift(rng);
            wen   = rng[0];
            wrd   = rng[5:1];
            flush = (rng[11:8] == 4'h0);
            hold  = (rng[15:12] == 4'h0);
            rng  = xorshift(rng);
            wdat = rng;
            // fetch presents the same word again after a load-use stall
            do begin
                send("random", ins, flush, hold, wen, wrd, wdat, st);
            end while (st);
        end

        // load-use on rs1, then the held instruction goes through
        decode_one("lu_load", make_instr(rv_pkg::op_load, 5'd5, 5'd1, 5'd0));
        decode_one("lu_dep_rs1", make_instr(rv_pkg::op_reg, 5'd6, 5'd5, 5'd2));
        decode_one("lu_held_rs1", make_instr(rv_pkg::op_reg, 5'd6, 5'd5, 5'd2));
        // store data through rs2
        decode_one("lu_load", make_instr(rv_pkg::op_load, 5'd7, 5'd1, 5'd0));
        decode_one("lu_dep_rs2", make_instr(rv_pkg::op_store, 5'd0, 5'd2, 5'd7));
        decode_one("lu_held_rs2", make_instr(rv_pkg::op_store, 5'd0, 5'd2, 5'd7));
        // x0 destination never stalls
        decode_one("lu_load_x0", make_instr(rv_pkg::op_load, 5'd0, 5'd1, 5'd0));
        decode_one("lu_x0_dep", make_instr(rv_pkg::op_reg, 5'd4, 5'd0, 5'd0));
        // lui fields that look like rs1 and rs2 are immediate bits
        decode_one("lu_load", make_instr(rv_pkg::op_load, 5'd7, 5'd1, 5'd0));
        decode_one("lu_lui", make_instr(rv_pkg::op_lui, 5'd8, 5'd7, 5'd7));

        // flush wins over any instruction
        send("flush_jal", make_instr(rv_pkg::op_jal, 5'd1, 5'd3, 5'd4),
             1'b1, 1'b0, 1'b0, 5'd0, 32'd0, st);
        send("flush_load", make_instr(rv_pkg::op_load, 5'd5, 5'd1, 5'd0),
             1'b1, 1'b0, 1'b0, 5'd0, 32'd0, st);
        // div hold freezes the outputs while write-back goes on
        decode_one("hold_setup", make_instr(rv_pkg::op_imm, 5'd4, 5'd2, 5'd17));
        repeat (4) begin
            send("hold", make_instr(rv_pkg::op_store, 5'd0, 5'd3, 5'd4),
                 1'b0, 1'b1, 1'b0, 5'd0, 32'd0, st);
        end
        send("hold_wb", make_instr(rv_pkg::op_store, 5'd0, 5'd3, 5'd4),
             1'b0, 1'b1, 1'b1, 5'd4, 32'h0bad_f00d, st);
        decode_one("hold_release", make_instr(rv_pkg::op_store, 5'd0, 5'd3, 5'd4));
        send("hold_flush", make_instr(rv_pkg::op_reg, 5'd2, 5'd3, 5'd4),
             1'b1, 1'b1, 1'b0, 5'd0, 32'd0, st);
        decode_one("final_nop", nop);

        // let the last result reach the compare process
        @(negedge clk);
        $display("checks %0d, errors %0d, results not compared %0d",
                 n_checks, n_errors, exp_q.size());
        if (n_errors == 0 && exp_q.size() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/rv_pkg.sv
hw/decode_ctrl_if.sv
hw/imm_gen.sv
hw/control_unit.sv
hw/register_file.sv
hw/hazard_unit.sv
hw/instruction_decode.sv
test/tb_instruction_decode.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_instruction_decode
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
